/* logic/access_decode.sv */
`default_nettype none

module access_decode (
   input  wire                      clk_i,
   input  wire                      arst_n_i,
   // write side, byte addressed
   input  wire                      w_en_i,
   input  asym_ram_pkg::byte_addr_t w_addr_i,
   input  asym_ram_pkg::byte_t      w_data_i,
   // read side, byte addressed
   input  wire                      r_en_i,
   input  asym_ram_pkg::byte_addr_t r_addr_i,
   // decoded commands to the banks
   bank_cmd_if.decode               cmd
);

   logic [asym_ram_pkg::LANE_W-1:0] w_lane_sel;
   asym_ram_pkg::lane_en_t          lane_en_d;
   asym_ram_pkg::lane_en_t          lane_en_q;
   asym_ram_pkg::word_addr_t        w_word_addr_q;
   asym_ram_pkg::byte_t             w_data_q;

   // low address bits pick the byte lane
   assign w_lane_sel = w_addr_i[asym_ram_pkg::LANE_W-1:0];

   always_comb begin
      lane_en_d = '0;
      if (w_en_i) begin
         lane_en_d = asym_ram_pkg::lane_en_t'(1) << w_lane_sel;
      end
   end

   // lane enables are control state
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         lane_en_q <= '0;
      end else begin
         lane_en_q <= lane_en_d;
      end
   end

   // payload only moves on a write
   always_ff @(posedge clk_i) begin
      if (w_en_i) begin
         w_word_addr_q <= w_addr_i[asym_ram_pkg::ADDR_W-1:asym_ram_pkg::LANE_W];
         w_data_q      <= w_data_i;
      end
   end

   assign cmd.wr_lane_en   = lane_en_q;
   assign cmd.wr_word_addr = w_word_addr_q;
   assign cmd.wr_data      = w_data_q;

   // read goes straight through, lane bits dropped
   assign cmd.rd_en        = r_en_i;
   assign cmd.rd_word_addr = r_addr_i[asym_ram_pkg::ADDR_W-1:asym_ram_pkg::LANE_W];

endmodule

`default_nettype wire

/* logic/asym_ram_2p.sv */
`default_nettype none

module asym_ram_2p (
   input  wire                      clk_i,
   input  wire                      arst_n_i,
   // write port, one byte per strobe
   input  wire                      w_en_i,
   input  asym_ram_pkg::byte_addr_t w_addr_i,
   input  asym_ram_pkg::byte_t      w_data_i,
   // read port, one word per strobe
   input  wire                      r_en_i,
   input  asym_ram_pkg::byte_addr_t r_addr_i,
   output logic                     r_valid_o,
   output asym_ram_pkg::word_t      r_data_o
);

   asym_ram_pkg::word_t rd_word;
   logic                rd_word_valid;

   // decoded commands between decode and banks
   bank_cmd_if cmd ();

   access_decode u_decode (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .w_en_i  (w_en_i),
      .w_addr_i(w_addr_i),
      .w_data_i(w_data_i),
      .r_en_i  (r_en_i),
      .r_addr_i(r_addr_i),
      .cmd     (cmd.decode)
   );

   // four byte-wide banks
   bank_array u_banks (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .cmd            (cmd.bank),
      .rd_word_o      (rd_word),
      .rd_word_valid_o(rd_word_valid)
   );

   // output register, two cycle read latency in total
   read_assemble u_result (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .rd_word_i      (rd_word),
      .rd_word_valid_i(rd_word_valid),
      .r_valid_o      (r_valid_o),
      .r_data_o       (r_data_o)
   );

endmodule

`default_nettype wire

/* logic/asym_ram_pkg.sv */
`default_nettype none

package asym_ram_pkg;

   // write side is one byte per strobe
   localparam int W_DATA_W = 8;

   // read side returns a full word per strobe
   localparam int R_DATA_W = 32;

   // byte address space, 1024 bytes
   localparam int ADDR_W = 10;

   // one bank per byte lane of the read word
   localparam int LANES = R_DATA_W / W_DATA_W;

   // lane index taken from the low address bits
   localparam int LANE_W = $clog2(LANES);

   // address inside one bank
   localparam int WORD_ADDR_W = ADDR_W - LANE_W;

   // write data
   typedef logic [W_DATA_W-1:0] byte_t;

   // read data, little-endian lanes
   typedef logic [R_DATA_W-1:0] word_t;

   // byte address on both ports
   typedef logic [ADDR_W-1:0] byte_addr_t;

   // bank address
   typedef logic [WORD_ADDR_W-1:0] word_addr_t;

   // one-hot lane write enables
   typedef logic [LANES-1:0] lane_en_t;

endpackage

`default_nettype wire

/* logic/bank_array.sv */
`default_nettype none

module bank_array (
   input  wire                 clk_i,
   input  wire                 arst_n_i,
   bank_cmd_if.bank            cmd,
   output asym_ram_pkg::word_t rd_word_o,
   output logic                rd_word_valid_o
);

   // one read byte per lane
   asym_ram_pkg::byte_t lane_rd [asym_ram_pkg::LANES];

   for (genvar g = 0; g < asym_ram_pkg::LANES; g++) begin : g_bank
      ram_2p u_ram (
         .clk_i   (clk_i),
         .w_en_i  (cmd.wr_lane_en[g]),
         .w_addr_i(cmd.wr_word_addr),
         .w_data_i(cmd.wr_data),
         .r_en_i  (cmd.rd_en),
         .r_addr_i(cmd.rd_word_addr),
         .r_data_o(lane_rd[g])
      );
   end

   // lane k goes to byte k of the word
   always_comb begin
      rd_word_o = '0;
      for (int k = 0; k < asym_ram_pkg::LANES; k++) begin
         rd_word_o[k*asym_ram_pkg::W_DATA_W +: asym_ram_pkg::W_DATA_W] = lane_rd[k];
      end
   end

   // bank data is ready one cycle after the strobe
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rd_word_valid_o <= 1'b0;
      end else begin
         rd_word_valid_o <= cmd.rd_en;
      end
   end

endmodule

`default_nettype wire

/* logic/bank_cmd_if.sv */
`default_nettype none

interface bank_cmd_if;

   // write command, at most one lane enabled
   asym_ram_pkg::lane_en_t   wr_lane_en;
   asym_ram_pkg::word_addr_t wr_word_addr;
   asym_ram_pkg::byte_t      wr_data;

   // read command, all lanes at once
   logic                     rd_en;
   asym_ram_pkg::word_addr_t rd_word_addr;

   modport decode (
      output wr_lane_en,
      output wr_word_addr,
      output wr_data,
      output rd_en,
      output rd_word_addr
   );

   modport bank (
      input wr_lane_en,
      input wr_word_addr,
      input wr_data,
      input rd_en,
      input rd_word_addr
   );

endinterface

`default_nettype wire

/* logic/ram_2p.sv */
`default_nettype none

module ram_2p (
   input  wire                      clk_i,
   // write port
   input  wire                      w_en_i,
   input  asym_ram_pkg::word_addr_t w_addr_i,
   input  asym_ram_pkg::byte_t      w_data_i,
   // read port
   input  wire                      r_en_i,
   input  asym_ram_pkg::word_addr_t r_addr_i,
   output asym_ram_pkg::byte_t      r_data_o
);

   // one byte per bank word
   asym_ram_pkg::byte_t mem [2**asym_ram_pkg::WORD_ADDR_W];

   always_ff @(posedge clk_i) begin
      if (w_en_i) begin
         mem[w_addr_i] <= w_data_i;
      end
   end

   // sync read, old data on a same-word collision
   always_ff @(posedge clk_i) begin
      if (r_en_i) begin
         r_data_o <= mem[r_addr_i];
      end
   end

endmodule

`default_nettype wire

/* logic/read_assemble.sv */
`default_nettype none

module read_assemble (
   input  wire                 clk_i,
   input  wire                 arst_n_i,
   // word from the banks
   input  asym_ram_pkg::word_t rd_word_i,
   input  wire                 rd_word_valid_i,
   // read result port
   output logic                r_valid_o,
   output asym_ram_pkg::word_t r_data_o
);

   // one-cycle strobe, follows the bank valid
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         r_valid_o <= 1'b0;
      end else begin
         r_valid_o <= rd_word_valid_i;
      end
   end

   // data is kept until the next read lands
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         r_data_o <= '0;
      end else if (rd_word_valid_i) begin
         r_data_o <= rd_word_i;
      end
   end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the asym_ram_2p testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

TOP=asym_ram_2p_tb
LOG=sim.log
PASS_MSG="PASS: all tests"

if ! command -v verilator > /dev/null 2>&1; then
   echo "verilator not found in PATH"
   exit 1
fi

verilator --binary --timing -Wno-fatal -f verilog.f --top-module "$TOP" -o "$TOP"
status=$?
if [ "$status" -ne 0 ]; then
   echo "build failed with status $status"
   exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "$PASS_MSG" "$LOG"; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed, see $LOG"
   exit 1
fi

/* verif/tb_util.svh */
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

   // 16-bit Fibonacci LFSR, taps 16 14 13 11
   logic [15:0] lfsr_state = 16'd49;

   // one byte per address, follows every write the testbench drives
   asym_ram_pkg::byte_t shadow [2**asym_ram_pkg::ADDR_W];

   function automatic logic lfsr_next_bit();
      logic fb;
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      return fb;
   endfunction

   // one LFSR step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_next_bit()};
      end
      return v;
   endfunction

   function automatic void shadow_write(
      input asym_ram_pkg::byte_addr_t addr,
      input asym_ram_pkg::byte_t      data
   );
      shadow[addr] = data;
   endfunction

   // little-endian word around a byte address
   function automatic asym_ram_pkg::word_t expected_word(
      input asym_ram_pkg::byte_addr_t addr
   );
      asym_ram_pkg::word_t      w;
      asym_ram_pkg::byte_addr_t base;
      // low bits of a read address are ignored
      base = addr & ~asym_ram_pkg::byte_addr_t'(asym_ram_pkg::LANES - 1);
      w = '0;
      for (int k = 0; k < asym_ram_pkg::LANES; k++) begin
         // lane k holds the byte at base + k
         w[k*asym_ram_pkg::W_DATA_W +: asym_ram_pkg::W_DATA_W] =
            shadow[base + asym_ram_pkg::byte_addr_t'(k)];
      end
      return w;
   endfunction

`endif

/* verif/asym_ram_2p_tb.sv */
`default_nettype none

module asym_ram_2p_tb;

   // cycles driven by each phase
   localparam int IDLE_OPS  = 8;
   localparam int LANE_OPS  = 16;
   localparam int FILL_OPS  = 2**asym_ram_pkg::ADDR_W + 2**asym_ram_pkg::WORD_ADDR_W + 8;
   localparam int BURST_OPS = 32;
   localparam int MIX_OPS   = 600;
   localparam int DRAIN_OPS = 8;
   localparam int TOTAL_OPS = IDLE_OPS + LANE_OPS + FILL_OPS + BURST_OPS + MIX_OPS + DRAIN_OPS;
   localparam int WATCHDOG_CYCLES = TOTAL_OPS * 4 + 50;

   // low from the start, so time zero has no clock edge
   logic                     clk_i = 1'b0;
   logic                     arst_n_i;
   logic                     w_en_i;
   asym_ram_pkg::byte_addr_t w_addr_i;
   asym_ram_pkg::byte_t      w_data_i;
   logic                     r_en_i;
   asym_ram_pkg::byte_addr_t r_addr_i;
   logic                     r_valid_o;
   asym_ram_pkg::word_t      r_data_o;

   int checks = 0;
   int errors = 0;
   int cycle_cnt = 0;

   // reads in flight, oldest first
   asym_ram_pkg::word_t      exp_word_q[$];
   asym_ram_pkg::byte_addr_t exp_addr_q[$];
   int                       exp_due_q[$];

   asym_ram_pkg::word_t      last_data;
   asym_ram_pkg::word_t      exp_word;
   asym_ram_pkg::byte_addr_t exp_addr;
   int                       exp_due;

   `include "tb_util.svh"

   asym_ram_2p dut (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .w_en_i   (w_en_i),
      .w_addr_i (w_addr_i),
      .w_data_i (w_data_i),
      .r_en_i   (r_en_i),
      .r_addr_i (r_addr_i),
      .r_valid_o(r_valid_o),
      .r_data_o (r_data_o)
   );

   initial begin
      forever begin
         #50 clk_i = ~clk_i;
      end
   end

   always @(posedge clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   // one cycle of stimulus, 10 units after the rising edge
   task automatic drive_cycle(
      input logic                     we,
      input asym_ram_pkg::byte_addr_t wa,
      input asym_ram_pkg::byte_t      wd,
      input logic                     re,
      input asym_ram_pkg::byte_addr_t ra
   );
      @(posedge clk_i);
      #10;
      w_en_i   = we;
      w_addr_i = wa;
      w_data_i = wd;
      r_en_i   = re;
      r_addr_i = ra;
      if (we) begin
         shadow_write(wa, wd);
      end
      if (re) begin
         exp_word_q.push_back(expected_word(ra));
         exp_addr_q.push_back(ra);
         // sampled at the next edge, valid one edge after that
         exp_due_q.push_back(cycle_cnt + 2);
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         drive_cycle(1'b0, '0, '0, 1'b0, '0);
      end
   endtask

   task automatic read_word(input asym_ram_pkg::byte_addr_t ra);
      drive_cycle(1'b0, '0, '0, 1'b1, ra);
   endtask

   task automatic lane_order_test();
      drive_cycle(1'b1, 10'h124, 8'h11, 1'b0, '0);
      drive_cycle(1'b1, 10'h125, 8'h22, 1'b0, '0);
      drive_cycle(1'b1, 10'h126, 8'h33, 1'b0, '0);
      drive_cycle(1'b1, 10'h127, 8'h44, 1'b0, '0);
      idle_cycles(2);
      read_word(10'h124);
      // nonzero lane bits, same word expected
      read_word(10'h127);
      idle_cycles(4);
   endtask

   task automatic fill_and_readback_test();
      for (int a = 0; a < 2**asym_ram_pkg::ADDR_W; a++) begin
         drive_cycle(1'b1, asym_ram_pkg::byte_addr_t'(a),
                     asym_ram_pkg::byte_t'(rand_bits(8)), 1'b0, '0);
      end
      idle_cycles(2);
      for (int w = 0; w < 2**asym_ram_pkg::WORD_ADDR_W; w++) begin
         read_word(asym_ram_pkg::byte_addr_t'(w * asym_ram_pkg::LANES));
      end
      idle_cycles(4);
   endtask

   task automatic back_to_back_read_test();
      for (int i = 0; i < 8; i++) begin
         read_word(asym_ram_pkg::byte_addr_t'(rand_bits(10)));
      end
      // gaps show that r_data_o holds
      for (int i = 0; i < 4; i++) begin
         read_word(asym_ram_pkg::byte_addr_t'(rand_bits(10)));
         idle_cycles(3);
      end
      idle_cycles(4);
   endtask

   task automatic random_mix_test();
      int                       last_wr [2**asym_ram_pkg::WORD_ADDR_W];
      logic                     we;
      logic                     re;
      asym_ram_pkg::byte_addr_t wa;
      asym_ram_pkg::byte_t      wd;
      asym_ram_pkg::byte_addr_t ra;
      foreach (last_wr[i]) begin
         last_wr[i] = -10;
      end
      for (int op = 0; op < MIX_OPS; op++) begin
         we = lfsr_next_bit();
         wa = asym_ram_pkg::byte_addr_t'(rand_bits(10));
         wd = asym_ram_pkg::byte_t'(rand_bits(8));
         re = lfsr_next_bit();
         ra = asym_ram_pkg::byte_addr_t'(rand_bits(10));
         if (we) begin
            last_wr[wa[asym_ram_pkg::ADDR_W-1:asym_ram_pkg::LANE_W]] = op;
         end
         // read stays two cycles clear of a write to its word
         if (re && (op - last_wr[ra[asym_ram_pkg::ADDR_W-1:asym_ram_pkg::LANE_W]] < 2)) begin
            re = 1'b0;
         end
         drive_cycle(we, wa, wd, re, ra);
      end
      idle_cycles(4);
   endtask

   task automatic finish_run();
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   endtask

   // compare at the falling edge, outputs are settled there
   always @(negedge clk_i) begin
      if (exp_due_q.size() > 0 && exp_due_q[0] < cycle_cnt) begin
         exp_word = exp_word_q.pop_front();
         exp_addr = exp_addr_q.pop_front();
         exp_due  = exp_due_q.pop_front();
         $display("ERROR at %0t: read of address 0x%03h never returned data", $time, exp_addr);
         errors++;
      end
      if (r_valid_o) begin
         if (exp_word_q.size() == 0) begin
            $display("ERROR at %0t: read data valid with no read outstanding", $time);
            errors++;
         end else begin
            exp_word = exp_word_q.pop_front();
            exp_addr = exp_addr_q.pop_front();
            exp_due  = exp_due_q.pop_front();
            checks++;
            if (cycle_cnt != exp_due) begin
               $display("CHECK FAILED at %0t: addr 0x%03h valid in cycle %0d, expected %0d",
                        $time, exp_addr, cycle_cnt, exp_due);
               errors++;
            end
            if (r_data_o !== exp_word) begin
               $display("CHECK FAILED at %0t: addr 0x%03h expected 0x%08h actual 0x%08h",
                        $time, exp_addr, exp_word, r_data_o);
               errors++;
            end
         end
         last_data = r_data_o;
      end else if (r_data_o !== last_data) begin
         $display("CHECK FAILED at %0t: r_data_o changed without valid, 0x%08h to 0x%08h",
                  $time, last_data, r_data_o);
         errors++;
         last_data = r_data_o;
      end
   end

   initial begin
      arst_n_i  = 1'b0;
      w_en_i    = 1'b0;
      w_addr_i  = '0;
      w_data_i  = '0;
      r_en_i    = 1'b0;
      r_addr_i  = '0;
      last_data = '0;
      repeat (3) @(posedge clk_i);
      #10;
      arst_n_i = 1'b1;

      // outputs quiet before the first read
      idle_cycles(3);
      @(negedge clk_i);
      checks++;
      if (r_valid_o !== 1'b0 || r_data_o !== '0) begin
         $display("CHECK FAILED at %0t: after reset valid %b data 0x%08h, expected 0 and 0",
                  $time, r_valid_o, r_data_o);
         errors++;
      end

      lane_order_test();
      fill_and_readback_test();
      back_to_back_read_test();
      random_mix_test();

      @(negedge clk_i);
      if (exp_word_q.size() != 0) begin
         $display("ERROR: %0d reads still pending at the end of the run", exp_word_q.size());
         errors++;
      end
      finish_run();
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk_i);
      $display("ERROR: run did not finish within %0d cycles", WATCHDOG_CYCLES);
      errors++;
      finish_run();
   end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+verif
logic/asym_ram_pkg.sv
logic/bank_cmd_if.sv
logic/ram_2p.sv
logic/access_decode.sv
logic/bank_array.sv
logic/read_assemble.sv
logic/asym_ram_2p.sv
verif/asym_ram_2p_tb.sv
